// ==== hw/tcdm_split_pkg.sv ====
// tcdm splitter shared definitions

package tcdm_split_pkg;

  // channel count and data widths
  localparam int unsigned NB_CHAN   = 2;  // narrow channels behind one wide port
  localparam int unsigned DW_WIDE   = 64; // accelerator word
  localparam int unsigned DW_NARROW = 32; // bank word
  localparam int unsigned AW        = 32; // byte address

  // byte enable widths follow from the data widths
  localparam int unsigned BE_WIDE   = DW_WIDE / 8;
  localparam int unsigned BE_NARROW = DW_NARROW / 8;

  // storage sizes
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned BANK_IW    = $clog2(BANK_WORDS); // bank word index
  localparam int unsigned FIFO_DEPTH = 2;                  // entries per queue
  localparam int unsigned FIFO_PW    = $clog2(FIFO_DEPTH);     // queue pointer
  localparam int unsigned FIFO_CW    = $clog2(FIFO_DEPTH + 1); // queue fill count

  // grant tracking of a partly granted wide request
  typedef enum logic {
    GNT_ST,
    NO_GNT_ST
  } gnt_state_t;

  // response tracking of a partly returned wide response
  typedef enum logic {
    RVALID_ST,
    NO_RVALID_ST
  } rvalid_state_t;

endpackage

// ==== hw/tcdm_chan_fifo.sv ====
// narrow channel request and response queues
`timescale 1ns/10ps

module tcdm_chan_fifo (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 req_i,
  input  logic [tcdm_split_pkg::AW-1:0]        add_i,
  input  logic                                 wen_i,
  input  logic [tcdm_split_pkg::BE_NARROW-1:0] be_i,
  input  logic [tcdm_split_pkg::DW_NARROW-1:0] data_i,
  output logic                                 gnt_o,
  output logic                                 r_valid_o,
  output logic [tcdm_split_pkg::DW_NARROW-1:0] r_data_o,
  input  logic                                 r_ready_i,
  output logic                                 bank_req_o,
  output logic [tcdm_split_pkg::AW-1:0]        bank_add_o,
  output logic                                 bank_wen_o,
  output logic [tcdm_split_pkg::BE_NARROW-1:0] bank_be_o,
  output logic [tcdm_split_pkg::DW_NARROW-1:0] bank_data_o,
  input  logic                                 bank_gnt_i,
  input  logic                                 bank_r_valid_i,
  input  logic [tcdm_split_pkg::DW_NARROW-1:0] bank_r_data_i
);

  // request queue storage, one array per field
  logic [tcdm_split_pkg::AW-1:0]        add_mem_q  [tcdm_split_pkg::FIFO_DEPTH];
  logic                                 wen_mem_q  [tcdm_split_pkg::FIFO_DEPTH];
  logic [tcdm_split_pkg::BE_NARROW-1:0] be_mem_q   [tcdm_split_pkg::FIFO_DEPTH];
  logic [tcdm_split_pkg::DW_NARROW-1:0] data_mem_q [tcdm_split_pkg::FIFO_DEPTH];
  logic [tcdm_split_pkg::DW_NARROW-1:0] rsp_mem_q  [tcdm_split_pkg::FIFO_DEPTH];

  logic [tcdm_split_pkg::FIFO_PW-1:0] req_wptr_q, req_rptr_q;
  logic [tcdm_split_pkg::FIFO_PW-1:0] rsp_wptr_q, rsp_rptr_q;
  logic [tcdm_split_pkg::FIFO_CW-1:0] req_cnt_q, rsp_cnt_q;
  logic [tcdm_split_pkg::FIFO_CW-1:0] out_cnt_q; // granted at the bank, answer not back yet
  logic req_push, req_pop, rsp_push, rsp_pop;

  function automatic logic [tcdm_split_pkg::FIFO_PW-1:0] next_ptr(
    input logic [tcdm_split_pkg::FIFO_PW-1:0] ptr
  );
    if (int'(ptr) == tcdm_split_pkg::FIFO_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign gnt_o    = req_cnt_q < tcdm_split_pkg::FIFO_DEPTH; // room in the request queue
  assign req_push = req_i & gnt_o;
  // a request leaves only when its answer already has a reserved slot
  assign bank_req_o = (req_cnt_q != '0) &&
                      ((out_cnt_q + rsp_cnt_q) < tcdm_split_pkg::FIFO_DEPTH);
  assign req_pop    = bank_req_o & bank_gnt_i;
  assign rsp_push   = bank_r_valid_i;  // always accepted thanks to the reservation
  assign r_valid_o  = rsp_cnt_q != '0;
  assign rsp_pop    = r_valid_o & r_ready_i;

  assign bank_add_o  = add_mem_q[req_rptr_q];
  assign bank_wen_o  = wen_mem_q[req_rptr_q];
  assign bank_be_o   = be_mem_q[req_rptr_q];
  assign bank_data_o = data_mem_q[req_rptr_q];
  assign r_data_o    = rsp_mem_q[rsp_rptr_q];

  always_ff @(posedge clk_i) begin
    if (req_push) begin
      add_mem_q[req_wptr_q]  <= add_i;
      wen_mem_q[req_wptr_q]  <= wen_i;
      be_mem_q[req_wptr_q]   <= be_i;
      data_mem_q[req_wptr_q] <= data_i;
    end
    if (rsp_push) begin
      rsp_mem_q[rsp_wptr_q] <= bank_r_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_wptr_q <= '0;
      req_rptr_q <= '0;
      rsp_wptr_q <= '0;
      rsp_rptr_q <= '0;
      req_cnt_q  <= '0;
      rsp_cnt_q  <= '0;
      out_cnt_q  <= '0;
    end else if (clear_i) begin // both queues emptied
      req_wptr_q <= '0;
      req_rptr_q <= '0;
      rsp_wptr_q <= '0;
      rsp_rptr_q <= '0;
      req_cnt_q  <= '0;
      rsp_cnt_q  <= '0;
      out_cnt_q  <= '0;
    end else begin
      if (req_push) req_wptr_q <= next_ptr(req_wptr_q);
      if (req_pop) req_rptr_q <= next_ptr(req_rptr_q);
      if (rsp_push) rsp_wptr_q <= next_ptr(rsp_wptr_q);
      if (rsp_pop) rsp_rptr_q <= next_ptr(rsp_rptr_q);
      req_cnt_q <= req_cnt_q + req_push - req_pop;
      rsp_cnt_q <= rsp_cnt_q + rsp_push - rsp_pop;
      out_cnt_q <= out_cnt_q + req_pop - rsp_push; // bank answers move from here to rsp
    end
  end

endmodule

// ==== hw/tcdm_bank.sv ====
// narrow single-port memory bank
`timescale 1ns/10ps

module tcdm_bank (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 stall_i,
  input  logic                                 req_i,
  input  logic [tcdm_split_pkg::AW-1:0]        add_i,
  input  logic                                 wen_i,   // high means read
  input  logic [tcdm_split_pkg::BE_NARROW-1:0] be_i,
  input  logic [tcdm_split_pkg::DW_NARROW-1:0] data_i,
  output logic                                 gnt_o,
  output logic                                 r_valid_o,
  output logic [tcdm_split_pkg::DW_NARROW-1:0] r_data_o
);

  logic [tcdm_split_pkg::DW_NARROW-1:0] mem_q [tcdm_split_pkg::BANK_WORDS];
  logic [tcdm_split_pkg::BANK_IW-1:0]   idx;
  logic                                 req_gnt;

  assign gnt_o   = ~stall_i; // free unless held off from outside
  assign req_gnt = req_i & gnt_o;

  // both halves of a wide word share one row, so the index is the address over 8
  assign idx = add_i[3 +: tcdm_split_pkg::BANK_IW];

  always_ff @(posedge clk_i) begin
    if (req_gnt && !wen_i) begin
      for (int b = 0; b < tcdm_split_pkg::BE_NARROW; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= data_i[8*b +: 8]; // only enabled bytes change
        end
      end
    end
  end

  // every granted access is answered on the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= req_gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_gnt) begin
      r_data_o <= wen_i ? mem_q[idx] : '0; // a write answers with zero
    end
  end

endmodule

// ==== hw/tcdm_split.sv ====
// wide to narrow tcdm request splitter
`timescale 1ns/10ps

module tcdm_split (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  // wide accelerator side
  input  logic                                 tgt_req_i,
  input  logic                                 tgt_wen_i,
  input  logic [tcdm_split_pkg::AW-1:0]        tgt_add_i,
  input  logic [tcdm_split_pkg::BE_WIDE-1:0]   tgt_be_i,
  input  logic [tcdm_split_pkg::DW_WIDE-1:0]   tgt_data_i,
  input  logic                                 tgt_r_ready_i,
  output logic                                 tgt_gnt_o,
  output logic                                 tgt_r_valid_o,
  output logic [tcdm_split_pkg::DW_WIDE-1:0]   tgt_r_data_o,
  // narrow channel side, one slice per channel
  output logic [tcdm_split_pkg::NB_CHAN-1:0]   ini_req_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::AW-1:0] ini_add_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0]   ini_wen_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::BE_NARROW-1:0] ini_be_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_NARROW-1:0] ini_data_o,
  output logic [tcdm_split_pkg::NB_CHAN-1:0]   ini_r_ready_o,
  input  logic [tcdm_split_pkg::NB_CHAN-1:0]   ini_gnt_i,
  input  logic [tcdm_split_pkg::NB_CHAN-1:0]   ini_r_valid_i,
  input  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_NARROW-1:0] ini_r_data_i
);

  tcdm_split_pkg::gnt_state_t    gnt_cs, gnt_ns;
  tcdm_split_pkg::rvalid_state_t rvalid_cs, rvalid_ns;

  logic [tcdm_split_pkg::NB_CHAN-1:0] req_mask_d, req_mask_q; // channels that took the request
  logic [tcdm_split_pkg::NB_CHAN-1:0] rdy_mask_d, rdy_mask_q; // channels that showed a response
  logic [tcdm_split_pkg::NB_CHAN-1:0] chan_gnt;  // granted now or earlier in this request
  logic [tcdm_split_pkg::NB_CHAN-1:0] chan_xfer; // sub-request accepted this cycle

  for (genvar ii = 0; ii < tcdm_split_pkg::NB_CHAN; ii++) begin : g_chan
    // each channel sits one narrow word above the previous one
    assign ini_add_o[ii]  = tgt_add_i + ii * (tcdm_split_pkg::DW_NARROW / 8);
    assign ini_wen_o[ii]  = tgt_wen_i;
    assign ini_be_o[ii]   = tgt_be_i[ii*tcdm_split_pkg::BE_NARROW +: tcdm_split_pkg::BE_NARROW];
    assign ini_data_o[ii] = tgt_data_i[ii*tcdm_split_pkg::DW_NARROW +: tcdm_split_pkg::DW_NARROW];

    // in NO_GNT_ST only the channels still missing their half are asked again
    assign ini_req_o[ii] = (gnt_cs == tcdm_split_pkg::GNT_ST) ? tgt_req_i :
                                                               tgt_req_i & ~req_mask_q[ii];
    assign chan_gnt[ii]  = (gnt_cs == tcdm_split_pkg::GNT_ST) ? ini_gnt_i[ii] :
                                                               ini_gnt_i[ii] | req_mask_q[ii];

    // both queues pop together, and only on a wide transfer
    assign ini_r_ready_o[ii] = tgt_r_valid_o & tgt_r_ready_i;
  end

  assign chan_xfer = ini_req_o & ini_gnt_i;
  assign tgt_gnt_o = &chan_gnt;

  // channel 1 forms the upper half of the wide word
  assign tgt_r_data_o = ini_r_data_i;

  // wide response is held back while the halves come in at different times
  assign tgt_r_valid_o = (rvalid_cs == tcdm_split_pkg::RVALID_ST) ? &ini_r_valid_i :
                                                                   &rdy_mask_d;

  always_comb begin
    gnt_ns = gnt_cs;
    case (gnt_cs)
      tcdm_split_pkg::GNT_ST: begin
        // some channel refused, remember who already took its half
        if (tgt_req_i && !(&ini_gnt_i)) begin
          gnt_ns = tcdm_split_pkg::NO_GNT_ST;
        end
      end
      tcdm_split_pkg::NO_GNT_ST: begin
        if (&chan_gnt) begin
          gnt_ns = tcdm_split_pkg::GNT_ST; // last missing half accepted
        end
      end
      default: gnt_ns = tcdm_split_pkg::GNT_ST;
    endcase
  end

  assign req_mask_d = (gnt_cs == tcdm_split_pkg::NO_GNT_ST) ? req_mask_q | chan_xfer :
                                                             chan_xfer;

  always_comb begin
    rvalid_ns = rvalid_cs;
    case (rvalid_cs)
      tcdm_split_pkg::RVALID_ST: begin
        // one half is back and the other is not
        if ((|ini_r_valid_i) && !(&ini_r_valid_i)) begin
          rvalid_ns = tcdm_split_pkg::NO_RVALID_ST;
        end
      end
      tcdm_split_pkg::NO_RVALID_ST: begin
        if (&(ini_r_valid_i | rdy_mask_q)) begin
          rvalid_ns = tcdm_split_pkg::RVALID_ST;
        end
      end
      default: rvalid_ns = tcdm_split_pkg::RVALID_ST;
    endcase
  end

  // a queue keeps its valid until popped, so the mask only ever grows
  assign rdy_mask_d = (rvalid_cs == tcdm_split_pkg::NO_RVALID_ST) ?
                      rdy_mask_q | ini_r_valid_i : ini_r_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_cs     <= tcdm_split_pkg::GNT_ST;
      req_mask_q <= '0;
    end else if (clear_i) begin
      gnt_cs     <= tcdm_split_pkg::GNT_ST;
      req_mask_q <= '0;
    end else begin
      gnt_cs     <= gnt_ns;
      req_mask_q <= req_mask_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_cs  <= tcdm_split_pkg::RVALID_ST;
      rdy_mask_q <= '0;
    end else if (clear_i) begin
      rvalid_cs  <= tcdm_split_pkg::RVALID_ST;
      rdy_mask_q <= '0;
    end else begin
      rvalid_cs  <= rvalid_ns;
      rdy_mask_q <= rdy_mask_d;
    end
  end

endmodule

// ==== hw/tcdm_split_top.sv ====
// splitter with two queued narrow banks
`timescale 1ns/10ps

module tcdm_split_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               req_i,
  input  logic                               wen_i,
  input  logic [tcdm_split_pkg::AW-1:0]      add_i,
  input  logic [tcdm_split_pkg::BE_WIDE-1:0] be_i,
  input  logic [tcdm_split_pkg::DW_WIDE-1:0] data_i,
  input  logic                               r_ready_i,
  input  logic [tcdm_split_pkg::NB_CHAN-1:0] stall_i,  // one hold-off per bank
  output logic                               gnt_o,
  output logic                               r_valid_o,
  output logic [tcdm_split_pkg::DW_WIDE-1:0] r_data_o
);

  // splitter to queue
  logic [tcdm_split_pkg::NB_CHAN-1:0] spl_req, spl_wen, spl_gnt, spl_r_valid, spl_r_ready;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::AW-1:0]        spl_add;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::BE_NARROW-1:0] spl_be;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_NARROW-1:0] spl_data, spl_r_data;
  // queue to bank
  logic [tcdm_split_pkg::NB_CHAN-1:0] bank_req, bank_wen, bank_gnt, bank_r_valid;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::AW-1:0]        bank_add;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::BE_NARROW-1:0] bank_be;
  logic [tcdm_split_pkg::NB_CHAN-1:0][tcdm_split_pkg::DW_NARROW-1:0] bank_data, bank_r_data;

  tcdm_split u_tcdm_split (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .tgt_req_i(req_i), .tgt_wen_i(wen_i), .tgt_add_i(add_i), .tgt_be_i(be_i),
    .tgt_data_i(data_i), .tgt_r_ready_i(r_ready_i), .tgt_gnt_o(gnt_o),
    .tgt_r_valid_o(r_valid_o), .tgt_r_data_o(r_data_o),
    .ini_req_o(spl_req), .ini_add_o(spl_add), .ini_wen_o(spl_wen), .ini_be_o(spl_be),
    .ini_data_o(spl_data), .ini_r_ready_o(spl_r_ready), .ini_gnt_i(spl_gnt),
    .ini_r_valid_i(spl_r_valid), .ini_r_data_i(spl_r_data)
  );

  for (genvar ii = 0; ii < tcdm_split_pkg::NB_CHAN; ii++) begin : g_chan
    tcdm_chan_fifo u_fifo (
      .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
      .req_i(spl_req[ii]), .add_i(spl_add[ii]), .wen_i(spl_wen[ii]), .be_i(spl_be[ii]),
      .data_i(spl_data[ii]), .gnt_o(spl_gnt[ii]), .r_valid_o(spl_r_valid[ii]),
      .r_data_o(spl_r_data[ii]), .r_ready_i(spl_r_ready[ii]),
      .bank_req_o(bank_req[ii]), .bank_add_o(bank_add[ii]), .bank_wen_o(bank_wen[ii]),
      .bank_be_o(bank_be[ii]), .bank_data_o(bank_data[ii]), .bank_gnt_i(bank_gnt[ii]),
      .bank_r_valid_i(bank_r_valid[ii]), .bank_r_data_i(bank_r_data[ii])
    );

    tcdm_bank u_bank (
      .clk_i(clk_i), .rst_ni(rst_ni), .stall_i(stall_i[ii]),
      .req_i(bank_req[ii]), .add_i(bank_add[ii]), .wen_i(bank_wen[ii]), .be_i(bank_be[ii]),
      .data_i(bank_data[ii]), .gnt_o(bank_gnt[ii]), .r_valid_o(bank_r_valid[ii]),
      .r_data_o(bank_r_data[ii])
    );
  end

endmodule

// ==== sim/tb_tcdm_split.sv ====
// tcdm splitter testbench
`timescale 1ns/10ps

module tb_tcdm_split;

  localparam int OP_WR  = 0;
  localparam int OP_RD  = 1;
  localparam int OP_CLR = 2; // clear pulse while idle, no response

  typedef struct {
    int                                 op;
    int                                 idx;  // wide word index, address is idx * 8
    logic [tcdm_split_pkg::BE_WIDE-1:0] be;
    logic [tcdm_split_pkg::DW_WIDE-1:0] data;
    logic [tcdm_split_pkg::NB_CHAN-1:0] pat;  // banks to stall
    int                                 len;  // stall length in cycles, 0 leaves it alone
    int                                 rdy;  // 0 keeps r_ready_i high, 1 adds random gaps
  } entry_t;

  logic clk_i, rst_ni, clear_i, req_i, wen_i, r_ready_i, gnt_o, r_valid_o;
  logic [tcdm_split_pkg::AW-1:0]      add_i;
  logic [tcdm_split_pkg::BE_WIDE-1:0] be_i;
  logic [tcdm_split_pkg::DW_WIDE-1:0] data_i, r_data_o;
  logic [tcdm_split_pkg::NB_CHAN-1:0] stall_i;

  entry_t tab [64];
  logic [tcdm_split_pkg::DW_NARROW-1:0] model_lo [tcdm_split_pkg::BANK_WORDS]; // bank 0 image
  logic [tcdm_split_pkg::DW_NARROW-1:0] model_hi [tcdm_split_pkg::BANK_WORDS]; // bank 1 image
  logic [tcdm_split_pkg::DW_WIDE-1:0] exp_q [$]; // expected responses in issue order
  int mode_q [$];                                // r_ready behavior of each outstanding one
  int seed = 50343;
  int n_entries = 0, n_req = 0, gnt_count = 0, rsp_count = 0;
  int errors = 0, cycles = 0, limit = 0, stall_left = 0, stall_low = 0;
  int rsp_seen = 0; // every response beat, also any after the last expected one

  tcdm_split_top u_tcdm_split_top (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i), .req_i(req_i), .wen_i(wen_i),
    .add_i(add_i), .be_i(be_i), .data_i(data_i), .r_ready_i(r_ready_i), .stall_i(stall_i),
    .gnt_o(gnt_o), .r_valid_o(r_valid_o), .r_data_o(r_data_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, %0d of %0d responses seen", cycles, rsp_count, n_req);
      errors++;
      finish_run();
    end
  end

  // wide response beats counted apart from the checking loop
  always @(negedge clk_i) begin
    if (rst_ni && r_valid_o && r_ready_i) rsp_seen++;
  end

  task automatic check_rdata(input logic [tcdm_split_pkg::DW_WIDE-1:0] got,
                             input logic [tcdm_split_pkg::DW_WIDE-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch r_data_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_gnt_count(input string name, input int unsigned got,
                                 input int unsigned exp);
    if (got != exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic add_entry(input int op, input int idx, input logic [7:0] be,
                           input logic [1:0] pat, input int len, input int rdy);
    tab[n_entries].op   = op;
    tab[n_entries].idx  = idx;
    tab[n_entries].be   = be;
    tab[n_entries].data = {$random(seed), $random(seed)};
    tab[n_entries].pat  = pat;
    tab[n_entries].len  = len;
    tab[n_entries].rdy  = rdy;
    n_entries++;
    if (op != OP_CLR) n_req++;
  endtask

  // one clock step, inputs change 1 ns after the edge
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
    if (stall_left > 0) stall_left--;
    if (stall_left == 0) stall_i = '0; // stall window over
  endtask

  task automatic issue_entry(input int e);
    logic granted;
    if (tab[e].len > 0) begin
      stall_left = tab[e].len; // window runs on across the following entries
      stall_i    = tab[e].pat;
    end
    req_i   = 1'b1;
    wen_i   = (tab[e].op == OP_RD); // high means read
    add_i   = tab[e].idx * 8;
    be_i    = tab[e].be;
    data_i  = tab[e].data;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk_i);
      granted = gnt_o; // transfer happens at the coming edge
      if (stall_left > 0 && !gnt_o) stall_low++;
      step_cycle();
    end
    req_i = 1'b0;
    gnt_count++;
    if (tab[e].op == OP_WR) begin
      for (int b = 0; b < tcdm_split_pkg::BE_NARROW; b++) begin
        if (tab[e].be[b]) model_lo[tab[e].idx][8*b +: 8] = tab[e].data[8*b +: 8];
        if (tab[e].be[tcdm_split_pkg::BE_NARROW + b]) begin
          model_hi[tab[e].idx][8*b +: 8] = tab[e].data[tcdm_split_pkg::DW_NARROW + 8*b +: 8];
        end
      end
      exp_q.push_back('0); // a write answers with zero in both halves
    end else begin
      exp_q.push_back({model_hi[tab[e].idx], model_lo[tab[e].idx]});
    end
    mode_q.push_back(tab[e].rdy);
  endtask

  task automatic clear_idle();
    while (rsp_count != gnt_count) step_cycle(); // wait for every response to drain
    clear_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      if (r_valid_o) begin
        errors++;
        $display("r_valid_o went high during clear with nothing outstanding");
      end
      if (!gnt_o) begin
        errors++;
        $display("gnt_o stayed low during clear although the queues are empty");
      end
      step_cycle();
    end
    clear_i = 1'b0;
  endtask

  task automatic issue_all();
    for (int e = 0; e < n_entries; e++) begin
      if (tab[e].op == OP_CLR) clear_idle();
      else issue_entry(e);
    end
    while (stall_left > 0) step_cycle();
  endtask

  task automatic collect_responses();
    logic [tcdm_split_pkg::DW_WIDE-1:0] exp;
    int mode;
    int rnd;
    while (rsp_count < n_req) begin
      @(posedge clk_i);
      #1;
      mode      = (mode_q.size() > 0) ? mode_q[0] : 0;
      rnd       = $random(seed);
      r_ready_i = (mode == 0) || rnd[0]; // random gaps for the oldest response
      @(negedge clk_i);
      if (r_valid_o && r_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response arrived with no request outstanding");
        end else begin
          exp = exp_q.pop_front();
          mode_q.delete(0);
          check_rdata(r_data_o, exp);
        end
        rsp_count++;
      end
    end
    r_ready_i = 1'b1;
  endtask

  task automatic finish_run();
    $display("errors %0d, grants %0d, responses %0d", errors, gnt_count, rsp_seen);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    req_i     = 1'b0;
    wen_i     = 1'b1;
    add_i     = '0;
    be_i      = '0;
    data_i    = '0;
    r_ready_i = 1'b1;
    stall_i   = '0;

    // full words written, then read back
    for (int i = 0; i < 4; i++) add_entry(OP_WR, i, 8'hff, 2'b00, 0, 0);
    for (int i = 0; i < 4; i++) add_entry(OP_RD, i, 8'hff, 2'b00, 0, 0);
    // partial byte enables in both halves
    add_entry(OP_WR, 1, 8'h5a, 2'b00, 0, 0);
    add_entry(OP_WR, 2, 8'hc3, 2'b00, 0, 0);
    add_entry(OP_WR, 2, 8'h10, 2'b00, 0, 0);
    add_entry(OP_RD, 1, 8'hff, 2'b00, 0, 0);
    add_entry(OP_RD, 2, 8'hff, 2'b00, 0, 0);
    // bank 1 stalled long enough for its queue to fill
    add_entry(OP_WR, 4, 8'hff, 2'b10, 10, 0);
    for (int i = 5; i < 8; i++) add_entry(OP_WR, i, 8'hff, 2'b00, 0, 0);
    for (int i = 4; i < 8; i++) add_entry(OP_RD, i, 8'hff, 2'b00, 0, 0);
    add_entry(OP_WR, 8, 8'hff, 2'b01, 8, 0); // then bank 0 for a while
    add_entry(OP_RD, 8, 8'hff, 2'b00, 0, 0);
    // responses with r_ready_i gaps
    add_entry(OP_WR, 9, 8'hff, 2'b00, 0, 1);
    for (int i = 0; i < 4; i++) add_entry(OP_RD, i, 8'hff, 2'b00, 0, 1);
    add_entry(OP_RD, 9, 8'hff, 2'b00, 0, 1);
    add_entry(OP_RD, 4, 8'hff, 2'b00, 0, 1);
    // clear while idle, then a normal pair
    add_entry(OP_CLR, 0, 8'h00, 2'b00, 0, 0);
    add_entry(OP_WR, 10, 8'hff, 2'b00, 0, 0);
    add_entry(OP_RD, 10, 8'hff, 2'b00, 0, 0);
    limit = 40 * n_entries + 100;

    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fork
      issue_all();
      collect_responses();
    join

    // r_ready_i stays high here, so a repeated response would still be counted
    repeat (4 * tcdm_split_pkg::FIFO_DEPTH) step_cycle();
    check_gnt_count("response count", rsp_seen, gnt_count);
    if (stall_low == 0) begin
      errors++;
      $display("gnt_o never dropped while a bank was stalled");
    end
    finish_run();
  end

endmodule

// ==== build.f ====
hw/tcdm_split_pkg.sv
hw/tcdm_chan_fifo.sv
hw/tcdm_bank.sv
hw/tcdm_split.sv
hw/tcdm_split_top.sv
sim/tb_tcdm_split.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the splitter testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tcdm_split \
  -Mdir obj_dir -f build.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_tcdm_split > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" sim.log; then
  exit 0
fi
exit 1
